// ==== files.f ====
design/pipe_pkg.sv
design/isa_pkg.sv
design/fetch_stage_if.sv
design/pc_gen_stage.sv
design/inst_req_stage.sv
design/predecode_stage.sv
design/fetch_unit.sv
verif/inst_sram_model.sv
verif/fetch_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module fetch_unit_tb \
    --Mdir obj_dir -o fetch_unit_tb_sim \
    -f files.f

./obj_dir/fetch_unit_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== verif/fetch_unit_tb.sv ====
`timescale 1ns/1ps

module fetch_unit_tb import pipe_pkg::*; import isa_pkg::*; ();

    // words with a known class live at these addresses
    localparam logic [xlen-1:0] beq_addr     = 32'h1C00_0100;
    localparam logic [xlen-1:0] b_addr       = 32'h1C00_0200;
    localparam logic [xlen-1:0] jirl_addr    = 32'h1C00_0300;
    localparam logic [xlen-1:0] syscall_addr = 32'h1C00_0400;
    localparam logic [xlen-1:0] ertn_addr    = 32'h1C00_0500;
    localparam logic [xlen-1:0] alu_addr     = 32'h1C00_0600;
    localparam logic [xlen-1:0] odd_addr     = 32'h1C00_0702;
    localparam int              wait_limit   = 300;
    localparam int              n_rows       = 9;

    logic            clk;
    logic            resetn;
    redirect_kind_t  redirect_kind;
    logic [xlen-1:0] redirect_target;
    logic            inst_sram_req;
    logic [xlen-1:0] inst_sram_addr;
    logic            inst_sram_addr_ok;
    logic            inst_sram_data_ok;
    logic [xlen-1:0] inst_sram_rdata;
    logic [xlen-1:0] rdata_addr;
    logic            out_valid;
    logic            out_ready;
    logic [xlen-1:0] out_pc;
    logic [xlen-1:0] out_inst;
    excep_t          out_excep;
    inst_class_t     out_class;

    // test name, transfers first, redirect kind, target, class at target
    string           row_name   [n_rows] = '{"sequential", "branch_beq", "trap_syscall",
        "ertn_return", "branch_b", "jump_jirl", "adef_target", "trap_alu", "tail"};
    int              row_count  [n_rows] = '{10, 3, 5, 4, 2, 6, 3, 3, 8};
    redirect_kind_t  row_kind   [n_rows] = '{redir_none, redir_branch, redir_trap_entry,
        redir_ertn, redir_branch, redir_branch, redir_branch, redir_trap_entry, redir_none};
    logic [xlen-1:0] row_target [n_rows] = '{32'h0, beq_addr, syscall_addr, ertn_addr,
        b_addr, jirl_addr, odd_addr, alu_addr, 32'h0};
    inst_class_t     row_class  [n_rows] = '{cls_alu, cls_branch, cls_syscall, cls_ertn,
        cls_branch, cls_jump_reg, cls_illegal, cls_alu, cls_alu};

    // pc stream model
    logic [xlen-1:0] expect_pc;
    logic            first_on_path;
    inst_class_t     path_class;

    logic            held_valid;
    logic [xlen-1:0] held_pc;
    logic [xlen-1:0] held_inst;
    excep_t          held_excep;
    inst_class_t     held_class;
    int              transfers;
    int              checks;
    int              errors;
    int              timeouts;
    integer          seed;

    fetch_unit fetch_unit_inst (
        .clk               (clk),
        .resetn            (resetn),
        .redirect_kind     (redirect_kind),
        .redirect_target   (redirect_target),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .out_pc            (out_pc),
        .out_inst          (out_inst),
        .out_excep         (out_excep),
        .out_class         (out_class)
    );

    inst_sram_model #(
        .seed_init (32'h5409)
    ) inst_sram_model_inst (
        .clk        (clk),
        .resetn     (resetn),
        .req        (inst_sram_req),
        .addr       (inst_sram_addr),
        .addr_ok    (inst_sram_addr_ok),
        .data_ok    (inst_sram_data_ok),
        .rdata_addr (rdata_addr)
    );

    function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] a);
        case (a)
            beq_addr:     return {op_beq, 16'h0010, 5'd4, 5'd5};
            b_addr:       return {op_b, 26'h0000040};
            jirl_addr:    return {op_jirl, 16'h0000, 5'd1, 5'd0};
            syscall_addr: return {op_syscall_3r, 15'h0000};
            ertn_addr:    return {op_ertn, 15'h3800};
            alu_addr:     return {17'h00020, 5'd3, 5'd2, 5'd1};
            // filler decodes as alu and folds in every address bit
            default:      return {8'h02, a[25:2] ^ {18'h0, a[31:26]} ^ {22'h0, a[1:0]}};
        endcase
    endfunction

    assign inst_sram_rdata = word_at(rdata_addr);

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one clock cycle of stimulus and checking
    task automatic tick(input int row, input bit pulse);
        logic [xlen-1:0] exp_inst;
        inst_class_t     exp_class;
        excep_t          exp_excep;
        @(negedge clk);
        redirect_kind   = pulse ? row_kind[row] : redir_none;
        redirect_target = pulse ? row_target[row] : 32'h0;
        out_ready       = ($unsigned($random(seed)) % 32'd3) != 0;
        #1;
        check_value({row_name[row], " misaligned sram request"}, 32'h0,
                    32'(inst_sram_req && inst_sram_addr[1:0] != 2'b00));
        if (held_valid) begin
            check_value({row_name[row], " stalled valid"}, 32'h1, 32'(out_valid));
            check_value({row_name[row], " stalled pc"}, held_pc, out_pc);
            check_value({row_name[row], " stalled inst"}, held_inst, out_inst);
            check_value({row_name[row], " stalled excep"}, 32'(held_excep), 32'(out_excep));
            check_value({row_name[row], " stalled class"}, 32'(held_class), 32'(out_class));
        end
        held_valid = out_valid && !out_ready && !pulse;
        held_pc    = out_pc;
        held_inst  = out_inst;
        held_excep = out_excep;
        held_class = out_class;
        if (out_valid && out_ready) begin
            if (expect_pc[1:0] != 2'b00) begin
                exp_inst  = 32'h0;
                exp_class = cls_illegal;
                exp_excep = excep_adef;
            end else begin
                exp_inst  = word_at(expect_pc);
                exp_class = cls_alu;
                exp_excep = excep_none;
            end
            if (first_on_path) begin
                exp_class = path_class;
            end
            check_value({row_name[row], " pc"}, expect_pc, out_pc);
            check_value({row_name[row], " inst"}, exp_inst, out_inst);
            check_value({row_name[row], " excep"}, 32'(exp_excep), 32'(out_excep));
            check_value({row_name[row], " class"}, 32'(exp_class), 32'(out_class));
            expect_pc     = expect_pc + 32'd4;
            first_on_path = 1'b0;
            transfers++;
        end
        // older path is dead from the next edge on
        if (pulse) begin
            expect_pc     = row_target[row];
            first_on_path = 1'b1;
            path_class    = row_class[row];
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        int start;
        int waited;
        bit stop_run;
        seed            = 32'h5409;
        resetn          = 1'b0;
        redirect_kind   = redir_none;
        redirect_target = 32'h0;
        out_ready       = 1'b0;
        expect_pc       = reset_pc;
        first_on_path   = 1'b1;
        path_class      = cls_alu;
        held_valid      = 1'b0;
        transfers       = 0;
        checks          = 0;
        errors          = 0;
        timeouts        = 0;
        stop_run        = 1'b0;
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        for (int r = 0; r < n_rows && !stop_run; r++) begin
            start  = transfers;
            waited = 0;
            while (transfers - start < row_count[r] && waited < wait_limit) begin
                tick(r, 1'b0);
                waited++;
            end
            if (transfers - start < row_count[r]) begin
                $display("Timeout in %s: only %0d of %0d decode transfers arrived",
                         row_name[r], transfers - start, row_count[r]);
                timeouts++;
                stop_run = 1'b1;
            end else if (row_kind[r] != redir_none) begin
                tick(r, 1'b1);
            end
        end
        $display("transfers %0d, checks %0d, errors %0d, timeouts %0d",
                 transfers, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verif/inst_sram_model.sv ====
`timescale 1ns/1ps

module inst_sram_model import pipe_pkg::*; #(
    parameter int unsigned seed_init = 32'h5409
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            req,
    input  logic [xlen-1:0] addr,
    output logic            addr_ok,
    output logic            data_ok,
    output logic [xlen-1:0] rdata_addr
);

    // accepted requests in order with the cycle each one answers in
    logic [xlen-1:0] pend_addr [$];
    int              pend_due  [$];
    int              cycle;
    int              lat;
    integer          seed;
    logic            in_reset;

    // reset as the unit saw it at the last rising edge
    always @(posedge clk) begin
        in_reset <= !resetn;
    end

    initial begin
        seed       = seed_init;
        cycle      = 0;
        addr_ok    = 1'b0;
        data_ok    = 1'b0;
        rdata_addr = '0;
        forever begin
            @(negedge clk);
            cycle   = cycle + 1;
            data_ok = 1'b0;
            if (in_reset) begin
                pend_addr.delete();
                pend_due.delete();
                addr_ok = 1'b0;
            end else begin
                if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
                    data_ok    = 1'b1;
                    rdata_addr = pend_addr.pop_front();
                    void'(pend_due.pop_front());
                end
                // accept about three requests in four
                addr_ok = ($unsigned($random(seed)) % 32'd4) != 0;
                // inputs settle well before the rising edge
                #1;
                if (req && addr_ok) begin
                    lat = 1 + int'($unsigned($random(seed)) % 32'd4);
                    pend_addr.push_back(addr);
                    pend_due.push_back(cycle + lat);
                end
            end
        end
    end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import pipe_pkg::*; import isa_pkg::*; (
    input  logic            clk,
    input  logic            resetn,

    // redirect from later stages
    input  redirect_kind_t  redirect_kind,
    input  logic [xlen-1:0] redirect_target,

    // instruction sram
    output logic            inst_sram_req,
    output logic [xlen-1:0] inst_sram_addr,
    input  logic            inst_sram_addr_ok,
    input  logic            inst_sram_data_ok,
    input  logic [xlen-1:0] inst_sram_rdata,

    // towards decode
    output logic            out_valid,
    input  logic            out_ready,
    output logic [xlen-1:0] out_pc,
    output logic [xlen-1:0] out_inst,
    output excep_t          out_excep,
    output inst_class_t     out_class
);

    logic flush;

    fetch_stage_if pc_to_req ();
    fetch_stage_if req_to_pre ();

    // any redirect kills everything in flight
    assign flush = redirect_kind != redir_none;

    pc_gen_stage pc_gen_stage_inst (
        .clk             (clk),
        .resetn          (resetn),
        .redirect_kind   (redirect_kind),
        .redirect_target (redirect_target),
        .to_req          (pc_to_req.producer)
    );

    inst_req_stage inst_req_stage_inst (
        .clk               (clk),
        .resetn            (resetn),
        .flush             (flush),
        .from_pc           (pc_to_req.consumer),
        .to_pre            (req_to_pre.producer),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata)
    );

    predecode_stage predecode_stage_inst (
        .clk       (clk),
        .resetn    (resetn),
        .flush     (flush),
        .from_req  (req_to_pre.consumer),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pc    (out_pc),
        .out_inst  (out_inst),
        .out_excep (out_excep),
        .out_class (out_class)
    );

endmodule

// ==== design/predecode_stage.sv ====
`timescale 1ns/1ps

module predecode_stage import pipe_pkg::*; import isa_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            flush,
    fetch_stage_if.consumer from_req,
    output logic            out_valid,
    input  logic            out_ready,
    output logic [xlen-1:0] out_pc,
    output logic [xlen-1:0] out_inst,
    output excep_t          out_excep,
    output inst_class_t     out_class
);

    logic            valid_q;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] inst_q;
    excep_t          excep_q;
    inst_class_t     class_q;
    logic            load;
    logic            in_adef;

    function automatic inst_class_t classify(input inst_word_u w);
        // branch opcodes sit in the 2ri16 view
        if (w.fmt_2ri16.opcode inside {op_beq, op_bne, op_b, op_bl}) begin
            return cls_branch;
        end
        if (w.fmt_2ri16.opcode == op_jirl) begin
            return cls_jump_reg;
        end
        if (w.fmt_3r.opcode == op_syscall_3r) begin
            return cls_syscall;
        end
        if (w.fmt_3r.opcode == op_ertn) begin
            return cls_ertn;
        end
        return cls_alu;
    endfunction

    // single register that refills as it drains
    assign from_req.ready = ~flush & (~valid_q | out_ready);
    assign load           = from_req.valid & from_req.ready;
    assign in_adef        = from_req.excep == excep_adef;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (from_req.ready) begin
            valid_q <= from_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pc_q    <= from_req.pc;
            excep_q <= from_req.excep;
            inst_q  <= in_adef ? '0 : from_req.inst;
            class_q <= in_adef ? cls_illegal : classify(from_req.inst);
        end
    end

    assign out_valid = valid_q;
    assign out_pc    = pc_q;
    assign out_inst  = inst_q;
    assign out_excep = excep_q;
    assign out_class = class_q;

    out_hold_when_stalled: assert property (
        @(posedge clk) disable iff (!resetn)
        out_valid && !out_ready && !flush
            |=> out_valid && $stable(out_pc) && $stable(out_inst) && $stable(out_class)
    );

endmodule

// ==== design/inst_req_stage.sv ====
`timescale 1ns/1ps

module inst_req_stage import pipe_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            flush,
    fetch_stage_if.consumer from_pc,
    fetch_stage_if.producer to_pre,
    output logic            inst_sram_req,
    output logic [xlen-1:0] inst_sram_addr,
    input  logic            inst_sram_addr_ok,
    input  logic            inst_sram_data_ok,
    input  logic [xlen-1:0] inst_sram_rdata
);

    // in-flight queue with the oldest entry at head
    logic [xlen-1:0]  q_pc       [max_inflight];
    excep_t           q_excep    [max_inflight];
    logic             q_has_data [max_inflight];
    logic [xlen-1:0]  q_data     [max_inflight];

    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] discard_cnt;
    logic [cnt_w-1:0] waiting;
    logic [ptr_w-1:0] fill_idx;
    logic             fill_found;

    logic slot_free;
    logic is_adef;
    logic mem_idle;
    logic push;
    logic pop;
    logic fill;
    logic drop;

    assign slot_free = count < cnt_w'(max_inflight);
    assign is_adef   = from_pc.excep == excep_adef;
    // no new memory traffic until stale responses are gone
    assign mem_idle  = discard_cnt == '0;

    assign inst_sram_req  = from_pc.valid & slot_free & ~flush & ~is_adef & mem_idle;
    assign inst_sram_addr = from_pc.pc;

    // misaligned pc skips memory entirely
    assign from_pc.ready = slot_free & ~flush & (is_adef | (inst_sram_addr_ok & mem_idle));
    assign push          = from_pc.valid & from_pc.ready;

    assign to_pre.valid = (count != '0) && q_has_data[head];
    assign to_pre.pc    = q_pc[head];
    assign to_pre.inst  = q_data[head];
    assign to_pre.excep = q_excep[head];
    assign pop          = to_pre.valid & to_pre.ready;

    // oldest live entry still waiting on memory
    always_comb begin
        logic [ptr_w-1:0] idx;
        fill_found = 1'b0;
        fill_idx   = head;
        waiting    = '0;
        for (int i = 0; i < max_inflight; i++) begin
            idx = head + ptr_w'(i);
            if (cnt_w'(i) < count && !q_has_data[idx]) begin
                waiting = waiting + cnt_w'(1);
                if (!fill_found) begin
                    fill_found = 1'b1;
                    fill_idx   = idx;
                end
            end
        end
    end

    assign drop = inst_sram_data_ok & ~mem_idle;
    assign fill = inst_sram_data_ok & mem_idle & fill_found;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            discard_cnt <= '0;
        end else if (flush) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            // requests still at memory come back as garbage
            discard_cnt <= discard_cnt - cnt_w'(drop) + waiting - cnt_w'(fill);
        end else begin
            if (push) begin
                tail <= tail + ptr_w'(1);
            end
            if (pop) begin
                head <= head + ptr_w'(1);
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
            if (drop) begin
                discard_cnt <= discard_cnt - cnt_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_pc[tail]       <= from_pc.pc;
            q_excep[tail]    <= from_pc.excep;
            q_has_data[tail] <= is_adef;
            q_data[tail]     <= '0;
        end
        if (fill) begin
            q_has_data[fill_idx] <= 1'b1;
            q_data[fill_idx]     <= inst_sram_rdata;
        end
    end

    occupancy_bound: assert property (
        @(posedge clk) disable iff (!resetn)
        count <= cnt_w'(max_inflight)
    );

    // memory must not answer more than was asked
    no_spurious_data_ok: assert property (
        @(posedge clk) disable iff (!resetn)
        inst_sram_data_ok |-> (waiting != '0 || discard_cnt != '0)
    );

endmodule

// ==== design/pc_gen_stage.sv ====
`timescale 1ns/1ps

module pc_gen_stage import pipe_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  redirect_kind_t  redirect_kind,
    input  logic [xlen-1:0] redirect_target,
    fetch_stage_if.producer to_req
);

    logic            valid_q;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] pc_next;
    logic            fire;

    assign fire = to_req.valid & to_req.ready;

    // ertn over trap entry over branch over sequential
    always_comb begin
        pc_next = pc_q;
        if (redirect_kind == redir_ertn) begin
            pc_next = redirect_target;
        end else if (redirect_kind == redir_trap_entry) begin
            pc_next = redirect_target;
        end else if (redirect_kind == redir_branch) begin
            pc_next = redirect_target;
        end else if (fire) begin
            pc_next = pc_q + pc_step;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
            pc_q    <= reset_pc;
        end else begin
            // starts offering one cycle out of reset
            valid_q <= 1'b1;
            pc_q    <= pc_next;
        end
    end

    assign to_req.valid = valid_q;
    assign to_req.pc    = pc_q;
    // no instruction word yet at this point
    assign to_req.inst  = '0;
    assign to_req.excep = (pc_q[1:0] != 2'b00) ? excep_adef : excep_none;

    // offered pc held under back-pressure
    pc_hold_when_stalled: assert property (
        @(posedge clk) disable iff (!resetn)
        to_req.valid && !to_req.ready && redirect_kind == redir_none
            |=> $stable(to_req.pc)
    );

endmodule

// ==== design/fetch_stage_if.sv ====
`timescale 1ns/1ps

interface fetch_stage_if import pipe_pkg::*; ();

    logic            valid;
    logic            ready;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    excep_t          excep;

    modport producer (
        output valid,
        output pc,
        output inst,
        output excep,
        input  ready
    );

    modport consumer (
        input  valid,
        input  pc,
        input  inst,
        input  excep,
        output ready
    );

endinterface

// ==== design/isa_pkg.sv ====
package isa_pkg;

    // 3r format used also by system ops
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    // 2ri16 format of branches and jirl
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri16_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri16_t fmt_2ri16;
    } inst_word_u;

    // predecode result handed to decode
    typedef enum logic [2:0] {
        cls_alu      = 3'd0,
        cls_branch   = 3'd1,
        cls_jump_reg = 3'd2,
        cls_syscall  = 3'd3,
        cls_ertn     = 3'd4,
        cls_illegal  = 3'd5
    } inst_class_t;

    // 2ri16 opcodes, bits 31:26
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;

    // 3r opcodes, bits 31:15
    localparam logic [16:0] op_syscall_3r = 17'h00056;
    localparam logic [16:0] op_ertn       = 17'h00c90;

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

    // datapath and address width
    localparam int unsigned xlen = 32;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h1C00_0000;

    // sequential fetch step
    localparam logic [xlen-1:0] pc_step = 32'd4;

    // fetches outstanding at once
    localparam int unsigned max_inflight = 2;

    // queue index and occupancy widths
    localparam int unsigned ptr_w = $clog2(max_inflight);
    localparam int unsigned cnt_w = $clog2(max_inflight + 1);

    // fetch exception code
    typedef enum logic [0:0] {
        excep_none = 1'b0,
        excep_adef = 1'b1
    } excep_t;

    // one redirect source per cycle
    typedef enum logic [1:0] {
        redir_none       = 2'd0,
        redir_branch     = 2'd1,
        redir_trap_entry = 2'd2,
        redir_ertn       = 2'd3
    } redirect_kind_t;

endpackage
